// File: hdl/mips_isa_pkg.sv
// Instruction-set definitions for the MIPS integer core.
// Stages import this for field widths, opcode and function codes and ALU operations.
package mips_isa_pkg;

    localparam int WORD_W     = 32;
    localparam int REG_ADDR_W = 5;
    localparam int OPCODE_W   = 6;
    localparam int FUNCT_W    = 6;
    localparam int IMM_W      = 16;
    localparam int NUM_REGS   = 32;

    typedef logic [WORD_W-1:0]     word_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    // Fetch starts here after reset
    localparam word_t RESET_PC = 32'h0000_0000;

    // Primary opcodes of the supported subset
    typedef enum logic [OPCODE_W-1:0] {
        OP_SPECIAL = 6'h00,
        OP_J       = 6'h02,
        OP_BEQ     = 6'h04,
        OP_BNE     = 6'h05,
        OP_ADDIU   = 6'h09,
        OP_ORI     = 6'h0d,
        OP_LUI     = 6'h0f,
        OP_LW      = 6'h23,
        OP_SW      = 6'h2b
    } opcode_e;

    // Function codes under SPECIAL
    typedef enum logic [FUNCT_W-1:0] {
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_SLT  = 6'h2a
    } funct_e;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SLT,
        ALU_LUI
    } alu_op_e;

endpackage

// File: hdl/mips_pipe_pkg.sv
// Pipeline-register layouts, forwarding selects and stage timing types.
// Shared by the stages and the core top level.
package mips_pipe_pkg;
    import mips_isa_pkg::*;

    // Cycles until a value is needed or becomes ready
    typedef logic [1:0] stage_time_t;

    typedef enum logic [1:0] {
        FWD_REG,
        FWD_EX_MEM,
        FWD_MEM_WB
    } fwd_sel_e;

    typedef struct packed {
        word_t       rs_value;
        word_t       rt_value;
        reg_addr_t   rs_addr;
        reg_addr_t   rt_addr;
        word_t       imm;
        word_t       pre_result;   // lui value, known in decode
        alu_op_e     alu_op;
        logic        alu_src_imm;
        logic        mem_read;
        logic        mem_write;
        reg_addr_t   dst;          // zero when nothing is written
        stage_time_t new_time;
    } id_ex_t;

    typedef struct packed {
        word_t       alu_result;
        word_t       store_data;
        reg_addr_t   store_src;
        logic        mem_read;
        logic        mem_write;
        reg_addr_t   dst;
        stage_time_t new_time;
    } ex_mem_t;

    typedef struct packed {
        word_t     value;
        reg_addr_t dst;
    } mem_wb_t;

    // Operand multiplexer shared by every forwarding point
    function automatic word_t fwd_pick(fwd_sel_e sel, word_t reg_value,
                                       word_t mem_value, word_t wb_value);
        case (sel)
            FWD_EX_MEM: return mem_value;
            FWD_MEM_WB: return wb_value;
            default:    return reg_value;
        endcase
    endfunction

endpackage

// File: hdl/fetch_stage.sv
// Program counter of the core; the PC doubles as the instruction-memory address.
// Holds on stall and takes the decode-stage branch target when a branch is taken.
module fetch_stage (
    input  logic                clk,
    input  logic                reset,
    input  logic                stall,
    input  logic                branch_taken,
    input  mips_isa_pkg::word_t branch_target,
    output mips_isa_pkg::word_t pc,
    output mips_isa_pkg::word_t pc_plus4
);
    import mips_isa_pkg::*;

    assign pc_plus4 = pc + 32'd4;

    // The delay slot is already being fetched when the branch resolves
    always_ff @(posedge clk) begin
        if (!reset) begin
            pc <= RESET_PC;
        end else if (!stall) begin
            pc <= branch_taken ? branch_target : pc_plus4;
        end
    end

endmodule

// File: hdl/decode_stage.sv
// Instruction decoder with branch resolution.
// Produces the id_ex payload, register use times and the next-PC redirect.
module decode_stage (
    input  mips_isa_pkg::word_t         instr,
    input  mips_isa_pkg::word_t         pc_plus4,
    input  mips_isa_pkg::word_t         rs_value,
    input  mips_isa_pkg::word_t         rt_value,
    output mips_isa_pkg::reg_addr_t     rs_addr,
    output mips_isa_pkg::reg_addr_t     rt_addr,
    output logic                        rs_used,
    output logic                        rt_used,
    output mips_pipe_pkg::stage_time_t  rs_use_time,
    output mips_pipe_pkg::stage_time_t  rt_use_time,
    output logic                        branch_taken,
    output mips_isa_pkg::word_t         branch_target,
    output mips_pipe_pkg::id_ex_t       decoded
);
    import mips_isa_pkg::*;
    import mips_pipe_pkg::*;

    opcode_e          opcode;
    funct_e           funct;
    reg_addr_t        rd_addr;
    logic [IMM_W-1:0] imm16;
    word_t            sext_imm;
    logic             legal;

    assign opcode   = opcode_e'(instr[31:26]);
    assign funct    = funct_e'(instr[5:0]);
    assign rs_addr  = instr[25:21];
    assign rt_addr  = instr[20:16];
    assign rd_addr  = instr[15:11];
    assign imm16    = instr[IMM_W-1:0];
    assign sext_imm = {{(WORD_W-IMM_W){imm16[IMM_W-1]}}, imm16};

    always_comb begin
        // Defaults describe an instruction with no effect
        legal                = 1'b1;
        rs_used              = 1'b0;
        rt_used              = 1'b0;
        rs_use_time          = 2'd1;
        rt_use_time          = 2'd1;
        branch_taken         = 1'b0;
        branch_target        = pc_plus4 + {sext_imm[WORD_W-3:0], 2'b00};
        decoded.imm          = sext_imm;
        decoded.pre_result   = {imm16, 16'h0000};
        decoded.alu_op       = ALU_ADD;
        decoded.alu_src_imm  = 1'b1;
        decoded.mem_read     = 1'b0;
        decoded.mem_write    = 1'b0;
        decoded.dst          = '0;
        decoded.new_time     = '0;
        case (opcode)
            OP_SPECIAL: begin
                rs_used             = 1'b1;
                rt_used             = 1'b1;
                decoded.alu_src_imm = 1'b0;
                decoded.dst         = rd_addr;
                decoded.new_time    = 2'd1;
                case (funct)
                    FN_ADDU: decoded.alu_op = ALU_ADD;
                    FN_SUBU: decoded.alu_op = ALU_SUB;
                    FN_AND:  decoded.alu_op = ALU_AND;
                    FN_OR:   decoded.alu_op = ALU_OR;
                    FN_SLT:  decoded.alu_op = ALU_SLT;
                    default: begin
                        // All-zero word is the pipeline bubble
                        legal       = (instr == '0);
                        rs_used     = 1'b0;
                        rt_used     = 1'b0;
                        decoded.dst = '0;
                    end
                endcase
            end
            OP_ADDIU, OP_ORI, OP_LUI, OP_LW: begin
                rs_used          = (opcode != OP_LUI);
                decoded.dst      = rt_addr;
                decoded.new_time = (opcode == OP_LW) ? 2'd2 : 2'd1;
                decoded.mem_read = (opcode == OP_LW);
                if (opcode == OP_ORI) begin
                    decoded.alu_op = ALU_OR;
                    decoded.imm    = {{(WORD_W-IMM_W){1'b0}}, imm16};
                end
                if (opcode == OP_LUI) begin
                    decoded.alu_op = ALU_LUI;
                end
            end
            OP_SW: begin
                rs_used           = 1'b1;
                rt_used           = 1'b1;
                // Store data is only needed in the memory stage
                rt_use_time       = 2'd2;
                decoded.mem_write = 1'b1;
            end
            OP_BEQ, OP_BNE: begin
                rs_used      = 1'b1;
                rt_used      = 1'b1;
                rs_use_time  = 2'd0;
                rt_use_time  = 2'd0;
                branch_taken = (rs_value == rt_value) == (opcode == OP_BEQ);
            end
            OP_J: begin
                branch_taken  = 1'b1;
                branch_target = {pc_plus4[31:28], instr[25:0], 2'b00};
            end
            default: legal = 1'b0;
        endcase
        decoded.rs_value = rs_value;
        decoded.rt_value = rt_value;
        decoded.rs_addr  = rs_used ? rs_addr : '0;
        decoded.rt_addr  = rt_used ? rt_addr : '0;
    end

    always_comb begin
        if (!$isunknown(instr)) begin
            assert (legal) else $error("decode: unsupported instruction %h", instr);
        end
    end

endmodule

// File: hdl/register_file.sv
// Thirty-two general registers, written from write-back and read in decode.
// Reads see a same-cycle write; register zero always reads as zero.
module register_file (
    input  logic                    clk,
    input  logic                    reset,
    input  mips_isa_pkg::reg_addr_t rs_addr,
    input  mips_isa_pkg::reg_addr_t rt_addr,
    output mips_isa_pkg::word_t     rs_data,
    output mips_isa_pkg::word_t     rt_data,
    input  logic                    we,
    input  mips_isa_pkg::reg_addr_t waddr,
    input  mips_isa_pkg::word_t     wdata
);
    import mips_isa_pkg::*;

    word_t regs [NUM_REGS];

    assign rs_data = (rs_addr == '0) ? '0 : (we && waddr == rs_addr) ? wdata : regs[rs_addr];
    assign rt_data = (rt_addr == '0) ? '0 : (we && waddr == rt_addr) ? wdata : regs[rt_addr];

    always_ff @(posedge clk) begin
        if (we) begin
            regs[waddr] <= wdata;
        end
    end

    // Write-back drops destination zero before it reaches here
    no_zero_write: assert property (@(posedge clk) disable iff (!reset) we |-> waddr != '0)
        else $error("regfile: write to register zero");

endmodule

// File: hdl/hazard_unit.sv
// Stall and forwarding control, comparing use times against producer new times.
// The youngest producer wins, and forwarding only takes values that are ready.
module hazard_unit (
    input  mips_isa_pkg::reg_addr_t     rs_addr,
    input  mips_isa_pkg::reg_addr_t     rt_addr,
    input  logic                        rs_used,
    input  logic                        rt_used,
    input  mips_pipe_pkg::stage_time_t  rs_use_time,
    input  mips_pipe_pkg::stage_time_t  rt_use_time,
    input  mips_isa_pkg::reg_addr_t     id_ex_dst,
    input  mips_isa_pkg::reg_addr_t     ex_mem_dst,
    input  mips_isa_pkg::reg_addr_t     mem_wb_dst,
    input  mips_pipe_pkg::stage_time_t  id_ex_new_time,
    input  mips_pipe_pkg::stage_time_t  ex_mem_new_time,
    input  mips_isa_pkg::reg_addr_t     ex_rs_addr,
    input  mips_isa_pkg::reg_addr_t     ex_rt_addr,
    input  mips_isa_pkg::reg_addr_t     mem_store_src,
    output logic                        stall,
    output mips_pipe_pkg::fwd_sel_e     id_rs_sel,
    output mips_pipe_pkg::fwd_sel_e     id_rt_sel,
    output mips_pipe_pkg::fwd_sel_e     ex_rs_sel,
    output mips_pipe_pkg::fwd_sel_e     ex_rt_sel,
    output mips_pipe_pkg::fwd_sel_e     mem_store_sel
);
    import mips_isa_pkg::*;
    import mips_pipe_pkg::*;

    // Stall when the youngest matching producer is later than the use
    function automatic logic hold(reg_addr_t src, logic used, stage_time_t use_time);
        if (!used || src == '0) return 1'b0;
        if (src == id_ex_dst) return use_time < id_ex_new_time;
        if (src == ex_mem_dst) return use_time < ex_mem_new_time;
        return 1'b0;
    endfunction

    function automatic fwd_sel_e pick(reg_addr_t src, reg_addr_t near_dst,
                                      stage_time_t near_new, reg_addr_t far_dst);
        if (src == '0) return FWD_REG;
        if (src == near_dst) return (near_new == '0) ? FWD_EX_MEM : FWD_REG;
        if (src == far_dst) return FWD_MEM_WB;
        return FWD_REG;
    endfunction

    // A producer still in execute shadows older ones
    function automatic fwd_sel_e decode_pick(reg_addr_t src);
        if (src != '0 && src == id_ex_dst) return FWD_REG;
        return pick(src, ex_mem_dst, ex_mem_new_time, mem_wb_dst);
    endfunction

    always_comb begin
        stall         = hold(rs_addr, rs_used, rs_use_time) || hold(rt_addr, rt_used, rt_use_time);
        id_rs_sel     = decode_pick(rs_addr);
        id_rt_sel     = decode_pick(rt_addr);
        ex_rs_sel     = pick(ex_rs_addr, ex_mem_dst, ex_mem_new_time, mem_wb_dst);
        ex_rt_sel     = pick(ex_rt_addr, ex_mem_dst, ex_mem_new_time, mem_wb_dst);
        // Store data has only write-back left to look at
        mem_store_sel = pick(mem_store_src, '0, '0, mem_wb_dst);
    end

endmodule

// File: hdl/execute_stage.sv
// Execute stage with operand forwarding and the ALU.
// Also carries the store data and memory flags on to the memory stage.
module execute_stage (
    input  mips_pipe_pkg::id_ex_t   stage,
    input  mips_pipe_pkg::fwd_sel_e rs_sel,
    input  mips_pipe_pkg::fwd_sel_e rt_sel,
    input  mips_isa_pkg::word_t     mem_result,
    input  mips_isa_pkg::word_t     wb_result,
    output mips_pipe_pkg::ex_mem_t  result
);
    import mips_isa_pkg::*;
    import mips_pipe_pkg::*;

    word_t op_a;
    word_t rt_fwd;
    word_t op_b;
    word_t alu_out;

    assign op_a   = fwd_pick(rs_sel, stage.rs_value, mem_result, wb_result);
    assign rt_fwd = fwd_pick(rt_sel, stage.rt_value, mem_result, wb_result);
    assign op_b   = stage.alu_src_imm ? stage.imm : rt_fwd;

    always_comb begin
        case (stage.alu_op)
            ALU_SUB: alu_out = op_a - op_b;
            ALU_AND: alu_out = op_a & op_b;
            ALU_OR:  alu_out = op_a | op_b;
            ALU_SLT: alu_out = {31'b0, $signed(op_a) < $signed(op_b)};
            ALU_LUI: alu_out = stage.pre_result;
            default: alu_out = op_a + op_b;
        endcase
    end

    always_comb begin
        result.alu_result = alu_out;
        result.store_data = rt_fwd;
        result.store_src  = stage.rt_addr;
        result.mem_read   = stage.mem_read;
        result.mem_write  = stage.mem_write;
        result.dst        = stage.dst;
        // One stage closer to ready, never below zero
        result.new_time   = (stage.new_time == '0) ? '0 : stage.new_time - 2'd1;
    end

endmodule

// File: hdl/mips_core.sv
// Five-stage MIPS integer core with decode-stage branches and one delay slot.
// Memories sit outside on combinational read ports; the write-back port is the trace.
module mips_core (
    input  logic                    clk,
    input  logic                    reset,
    output mips_isa_pkg::word_t     imem_addr,
    input  mips_isa_pkg::word_t     imem_data,
    output mips_isa_pkg::word_t     dmem_addr,
    output mips_isa_pkg::word_t     dmem_wdata,
    output logic                    dmem_we,
    input  mips_isa_pkg::word_t     dmem_rdata,
    output logic                    reg_we,
    output mips_isa_pkg::reg_addr_t reg_waddr,
    output mips_isa_pkg::word_t     reg_wdata
);
    import mips_isa_pkg::*;
    import mips_pipe_pkg::*;

    word_t       pc_plus4;
    word_t       if_instr;
    word_t       if_pc_plus4;
    logic        stall;
    logic        branch_taken;
    word_t       branch_target;
    reg_addr_t   rs_addr;
    reg_addr_t   rt_addr;
    logic        rs_used;
    logic        rt_used;
    stage_time_t rs_use_time;
    stage_time_t rt_use_time;
    word_t       rf_rs_data;
    word_t       rf_rt_data;
    word_t       id_rs_value;
    word_t       id_rt_value;
    fwd_sel_e    id_rs_sel;
    fwd_sel_e    id_rt_sel;
    fwd_sel_e    ex_rs_sel;
    fwd_sel_e    ex_rt_sel;
    fwd_sel_e    mem_store_sel;
    id_ex_t      decoded;
    id_ex_t      id_ex;
    ex_mem_t     ex_result;
    ex_mem_t     ex_mem;
    mem_wb_t     mem_wb;

    fetch_stage fetch_i (
        .clk(clk), .reset(reset), .stall(stall), .branch_taken(branch_taken),
        .branch_target(branch_target), .pc(imem_addr), .pc_plus4(pc_plus4)
    );

    // if_id holds on stall; an all-zero word is the bubble
    always_ff @(posedge clk) begin
        if (!reset) begin
            if_instr <= '0;
        end else if (!stall) begin
            if_instr <= imem_data;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            if_pc_plus4 <= pc_plus4;
        end
    end

    // Decode operands see ready results from later stages
    assign id_rs_value = fwd_pick(id_rs_sel, rf_rs_data, ex_mem.alu_result, mem_wb.value);
    assign id_rt_value = fwd_pick(id_rt_sel, rf_rt_data, ex_mem.alu_result, mem_wb.value);

    decode_stage decode_i (
        .instr(if_instr), .pc_plus4(if_pc_plus4),
        .rs_value(id_rs_value), .rt_value(id_rt_value),
        .rs_addr(rs_addr), .rt_addr(rt_addr), .rs_used(rs_used), .rt_used(rt_used),
        .rs_use_time(rs_use_time), .rt_use_time(rt_use_time),
        .branch_taken(branch_taken), .branch_target(branch_target), .decoded(decoded)
    );

    register_file regs_i (
        .clk(clk), .reset(reset), .rs_addr(rs_addr), .rt_addr(rt_addr),
        .rs_data(rf_rs_data), .rt_data(rf_rt_data),
        .we(reg_we), .waddr(reg_waddr), .wdata(reg_wdata)
    );

    hazard_unit hazard_i (
        .rs_addr(rs_addr), .rt_addr(rt_addr), .rs_used(rs_used), .rt_used(rt_used),
        .rs_use_time(rs_use_time), .rt_use_time(rt_use_time),
        .id_ex_dst(id_ex.dst), .ex_mem_dst(ex_mem.dst), .mem_wb_dst(mem_wb.dst),
        .id_ex_new_time(id_ex.new_time), .ex_mem_new_time(ex_mem.new_time),
        .ex_rs_addr(id_ex.rs_addr), .ex_rt_addr(id_ex.rt_addr),
        .mem_store_src(ex_mem.store_src), .stall(stall),
        .id_rs_sel(id_rs_sel), .id_rt_sel(id_rt_sel),
        .ex_rs_sel(ex_rs_sel), .ex_rt_sel(ex_rt_sel), .mem_store_sel(mem_store_sel)
    );

    // Stall turns the decode output into a bubble
    always_ff @(posedge clk) begin
        if (!reset || stall) begin
            id_ex <= '0;
        end else begin
            id_ex <= decoded;
        end
    end

    execute_stage execute_i (
        .stage(id_ex), .rs_sel(ex_rs_sel), .rt_sel(ex_rt_sel),
        .mem_result(ex_mem.alu_result), .wb_result(mem_wb.value), .result(ex_result)
    );

    always_ff @(posedge clk) begin
        if (!reset) begin
            ex_mem <= '0;
        end else begin
            ex_mem <= ex_result;
        end
    end

    // Memory stage
    assign dmem_addr  = ex_mem.alu_result;
    assign dmem_we    = ex_mem.mem_write;
    assign dmem_wdata = fwd_pick(mem_store_sel, ex_mem.store_data, ex_mem.alu_result,
                                 mem_wb.value);

    always_ff @(posedge clk) begin
        if (!reset) begin
            mem_wb <= '0;
        end else begin
            mem_wb.value <= ex_mem.mem_read ? dmem_rdata : ex_mem.alu_result;
            mem_wb.dst   <= ex_mem.dst;
        end
    end

    // Write-back and trace
    assign reg_we    = (mem_wb.dst != '0);
    assign reg_waddr = mem_wb.dst;
    assign reg_wdata = mem_wb.value;

    // Worst case is a load feeding a branch, two cycles
    stall_bound: assert property (@(posedge clk) disable iff (!reset)
        stall ##1 stall |=> !stall)
        else $error("core: stall lasted more than two cycles");

endmodule

// File: tb/mips_core_tb.sv
// Testbench for the MIPS core. Runs the golden program and checks every register and memory write.
// Program words and expected writes are read from tb/program_golden.hex.
module mips_core_tb;
    import mips_isa_pkg::*;

    localparam int MEM_WORDS    = 256;
    localparam int GOLDEN_WORDS = 512;
    localparam int NUM_TESTS    = 6;
    localparam int DRAIN_CYCLES = 12;

    // One expected write, tagged with the behavior it belongs to
    typedef struct packed {
        int    test;
        word_t addr;
        word_t data;
    } write_t;

    logic      clk = 1'b0;
    logic      reset;
    word_t     imem_addr;
    word_t     imem_data;
    word_t     dmem_addr;
    word_t     dmem_wdata;
    logic      dmem_we;
    word_t     dmem_rdata;
    logic      reg_we;
    reg_addr_t reg_waddr;
    word_t     reg_wdata;

    word_t golden [GOLDEN_WORDS];
    word_t imem [MEM_WORDS];
    word_t dmem [MEM_WORDS];
    string test_names [1:NUM_TESTS];
    int    left_in_test [1:NUM_TESTS];
    int    test_errors [1:NUM_TESTS];
    int    prog_len;
    int    reg_total;
    int    mem_total;
    int    reg_base;
    int    mem_base;
    int    reg_next;
    int    mem_next;
    int    errors;

    mips_core dut_i (
        .clk(clk), .reset(reset), .imem_addr(imem_addr), .imem_data(imem_data),
        .dmem_addr(dmem_addr), .dmem_wdata(dmem_wdata), .dmem_we(dmem_we),
        .dmem_rdata(dmem_rdata), .reg_we(reg_we), .reg_waddr(reg_waddr), .reg_wdata(reg_wdata)
    );

    always #5 clk = ~clk;

    // Both memories answer 1 unit after each rising edge
    initial begin
        imem_data  = '0;
        dmem_rdata = '0;
        forever begin
            @(posedge clk);
            #1;
            imem_data  = imem[imem_addr[9:2]];
            dmem_rdata = dmem[dmem_addr[9:2]];
        end
    end

    // Pair n of a table; the top byte of the first word is the behavior number
    function automatic write_t golden_entry(int base, int n);
        write_t w;
        w.test = {24'h0, golden[base + 2 * n][31:24]};
        w.addr = {8'h00, golden[base + 2 * n][23:0]};
        w.data = golden[base + 2 * n + 1];
        return w;
    endfunction

    task automatic close_entry(write_t w, logic ok);
        if (!ok) begin
            errors++;
            test_errors[w.test]++;
        end
        left_in_test[w.test]--;
        if (left_in_test[w.test] == 0) begin
            if (test_errors[w.test] == 0) begin
                $display("test %0d %s: passed", w.test, test_names[w.test]);
            end else begin
                $display("test %0d %s: failed, %0d errors", w.test, test_names[w.test],
                         test_errors[w.test]);
            end
        end
    endtask

    task automatic check_reg_write();
        write_t exp;
        logic   ok;
        assert (reg_next < reg_total)
            else begin
                $display("register r%0d written after the last expected write", reg_waddr);
                errors++;
            end
        if (reg_next < reg_total) begin
            exp = golden_entry(reg_base, reg_next);
            ok  = (reg_waddr == exp.addr[4:0]) && (reg_wdata == exp.data);
            assert (ok)
                else $display("FAIL reg_waddr=%h reg_wdata=%h, expected %h %h (write %0d)",
                              reg_waddr, reg_wdata, exp.addr[4:0], exp.data, reg_next);
            reg_next++;
            close_entry(exp, ok);
        end
    endtask

    task automatic check_mem_write();
        write_t exp;
        logic   ok;
        dmem[dmem_addr[9:2]] = dmem_wdata;
        assert (mem_next < mem_total)
            else begin
                $display("store to address %h after the last expected store", dmem_addr);
                errors++;
            end
        if (mem_next < mem_total) begin
            exp = golden_entry(mem_base, mem_next);
            ok  = (dmem_addr == exp.addr) && (dmem_wdata == exp.data);
            assert (ok)
                else $display("FAIL dmem_addr=%h dmem_wdata=%h, expected %h %h (store %0d)",
                              dmem_addr, dmem_wdata, exp.addr, exp.data, mem_next);
            mem_next++;
            close_entry(exp, ok);
        end
    endtask

    initial begin
        write_t w;
        int     limit;
        int     cycles;
        int     drain;
        int     passed;
        reset = 1'b0;
        errors = 0;
        reg_next = 0;
        mem_next = 0;
        test_names[1] = "alu results";
        test_names[2] = "forwarding";
        test_names[3] = "load-use stall";
        test_names[4] = "stores";
        test_names[5] = "branches and delay slot";
        test_names[6] = "register zero";
        for (int t = 1; t <= NUM_TESTS; t++) begin
            left_in_test[t] = 0;
            test_errors[t]  = 0;
        end
        for (int i = 0; i < MEM_WORDS; i++) begin
            imem[i] = '0;
            dmem[i] = '0;
        end
        $readmemh("tb/program_golden.hex", golden);
        prog_len  = golden[0];
        reg_total = golden[1];
        mem_total = golden[2];
        reg_base  = 3 + prog_len;
        mem_base  = reg_base + 2 * reg_total;
        for (int i = 0; i < prog_len; i++) begin
            imem[i] = golden[3 + i];
        end
        for (int i = 0; i < reg_total; i++) begin
            w = golden_entry(reg_base, i);
            left_in_test[w.test]++;
        end
        for (int i = 0; i < mem_total; i++) begin
            w = golden_entry(mem_base, i);
            left_in_test[w.test]++;
        end
        limit = 8 * prog_len + 50;

        repeat (10) @(posedge clk);
        #1;
        reset = 1'b1;

        // Keep watching a little after the last write to catch stray ones
        cycles = 0;
        drain  = 0;
        while (cycles < limit && drain < DRAIN_CYCLES) begin
            @(negedge clk);
            if (reg_we) begin
                check_reg_write();
            end
            if (dmem_we) begin
                check_mem_write();
            end
            cycles++;
            if (reg_next >= reg_total && mem_next >= mem_total) begin
                drain++;
            end
        end

        if (reg_next < reg_total || mem_next < mem_total) begin
            $display("timeout after %0d cycles: %0d register writes and %0d stores never came",
                     cycles, reg_total - reg_next, mem_total - mem_next);
            errors++;
        end
        passed = 0;
        for (int t = 1; t <= NUM_TESTS; t++) begin
            if (left_in_test[t] != 0) begin
                $display("test %0d %s: did not finish, %0d writes missing", t, test_names[t],
                         left_in_test[t]);
            end else if (test_errors[t] == 0) begin
                passed++;
            end
        end
        $display("tests: %0d passed, %0d failed, %0d errors", passed, NUM_TESTS - passed, errors);
        if (errors == 0 && passed == NUM_TESTS) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// File: tb/program_golden.hex
// Header: program length, register writes, stores. Then program words, then
// register writes as (GG0000RR value) and stores as (GGAAAAAA data), GG = behavior number
00000028 0000001c 00000003
// Program, four words per line
24010005 340200f0 3c031234 2404fffd  // 00 addiu ori lui addiu
00222821 00413023 00443824 00234025  // 10 addu subu and or
0081482a 0024502a 240b0010 016b5821  // 20 slt slt addiu addu
01616023 016c6825 35ae0100 240f0040  // 30 subu or ori addiu
24100abc adf00000 020e8821 adf10004  // 40 addiu sw addu sw
8df20000 02419821 8df40004 adf40008  // 50 lw addu lw sw
8df50000 12b00002 24160022 24170bad  // 60 lw beq slot skipped
16d60002 24180024 24190025 08000022  // 70 bne slot fallthrough j
241a0026 241b0bad 24000005 00220021  // 80 slot skipped r0 r0
241c0077 0001e821 08000026 00000000  // 90 addiu addu j-self slot
// Register writes
01000001 00000005 01000002 000000f0 01000003 12340000 01000004 fffffffd
01000005 000000f5 01000006 000000eb 01000007 000000f0 01000008 12340005
01000009 00000001 0100000a 00000000
0200000b 00000010 0200000b 00000020 0200000c 0000001b 0200000d 0000003b
0200000e 0000013b
0400000f 00000040 04000010 00000abc 04000011 00000bf7
03000012 00000abc 03000013 00000ac1 03000014 00000bf7
05000015 00000abc 05000016 00000022 05000018 00000024 05000019 00000025
0500001a 00000026
0600001c 00000077 0600001d 00000005
// Stores
04000040 00000abc 04000044 00000bf7 03000048 00000bf7

// File: all.f
hdl/mips_isa_pkg.sv
hdl/mips_pipe_pkg.sv
hdl/fetch_stage.sv
hdl/decode_stage.sv
hdl/register_file.sv
hdl/hazard_unit.sv
hdl/execute_stage.sv
hdl/mips_core.sv
tb/mips_core_tb.sv

// File: run.sh
#!/bin/sh
# Build the MIPS core testbench with Verilator, run it and check the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f all.f --top-module mips_core_tb -Mdir obj_dir
./obj_dir/Vmips_core_tb | tee sim.log

grep -q "PASS: all tests" sim.log
